// ==== tests/core_trace.txt ====
# T num stall: new test, stall 1 means instr_ready_o must drop at least once
# I word: instruction (hex), W rd data: expected writeback, S addr data: expected store
T 1 0
I 51000012
W 1 0012
I 52000034
W 2 0034
I 13120000
W 3 0046
I 24310000
W 4 0034
I 35320000
W 5 0004
I 46340000
W 6 0072
I 50100005
I 5700FFFF
W 7 FFFF
# add waits for the multiply result.
T 2 1
I 68120000
W 8 03A8
I 19810000
W 9 03BA
# mul r3 then addi r3, the addi value must win.
T 3 1
I 63220000
W 3 0A90
I 53100001
W 3 0013
I 1A300000
W A 0013
T 4 1
I 80120100
S 0112 0034
I 7B200200
W B A791
I 1CB10000
W C A7A3
I 800C0300
S 0300 A7A3
I 7DB00000
W D 0234
I 6E110000
W E 0144
I 7F100000
W F A5B7

// ==== list.f ====
logic/core_pkg.sv
logic/issue_if.sv
logic/instr_decode.sv
logic/hazard_unit.sv
logic/exec_pipe.sv
logic/mem_port.sv
logic/result_wb.sv
logic/core_top.sv
tests/core_assert.sv
tests/core_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the core testbench with Verilator, the log decides the result.
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -f list.f --top-module core_tb -o core_sim \
  && ./obj_dir/core_sim > sim.log 2>&1 \
  && ! grep -q "Done: errors found" sim.log \
  && grep -q "Done: no errors" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }

// ==== tests/core_tb.sv ====
`timescale 1ns/1ns

module core_tb;

  localparam int WAIT_LIMIT = 400;

  logic                clk_i         = 1'b0;
  logic                rst_n_i       = 1'b0;
  logic                instr_valid_i = 1'b0;
  core_pkg::instr_t    instr_i       = '0;
  logic                mem_ack_i     = 1'b0;
  core_pkg::data_t     mem_rdata_i   = '0;
  logic                instr_ready_o;
  logic                mem_req_o;
  logic                mem_we_o;
  core_pkg::data_t     mem_addr_o;
  core_pkg::data_t     mem_wdata_o;
  logic                wb_valid_o;
  core_pkg::reg_addr_t wb_rd_o;
  core_pkg::data_t     wb_data_o;

  // one queue of expected values per register.
  core_pkg::data_t  exp_q [core_pkg::REG_COUNT][$];
  core_pkg::data_t  st_addr_q [$];
  core_pkg::data_t  st_data_q [$];
  core_pkg::instr_t instr_q [$];

  int seed         = 32127;
  int ack_cnt      = -1;
  int errors       = 0;
  int test_errors  = 0;
  int tests_run    = 0;
  int tests_failed = 0;
  int stall_cycles = 0;
  int test_num     = 0;
  int need_stall   = 0;
  bit aborted      = 1'b0;
  bit sect_open    = 1'b0;

  always #50 clk_i = ~clk_i;

  core_top core_top_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .instr_valid_i (instr_valid_i),
    .instr_i       (instr_i),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i),
    .instr_ready_o (instr_ready_o),
    .mem_req_o     (mem_req_o),
    .mem_we_o      (mem_we_o),
    .mem_addr_o    (mem_addr_o),
    .mem_wdata_o   (mem_wdata_o),
    .wb_valid_o    (wb_valid_o),
    .wb_rd_o       (wb_rd_o),
    .wb_data_o     (wb_data_o)
  );

  bind core_top core_assert core_assert_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .mem_req_i   (mem_req_o),
    .mem_ack_i   (mem_ack_i),
    .wb_valid_i  (wb_valid_o),
    .wb_rd_i     (wb_rd_o),
    .alu_valid_i (alu_valid),
    .mul_valid_i (mul_valid)
  );

  task automatic check_eq(input core_pkg::data_t actual, input core_pkg::data_t expected,
                          input string what);
    if (actual !== expected) begin
      errors++;
      test_errors++;
      $display("[ERROR] %0t ns: %s, got %h expected %h", $time, what, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    errors++;
    test_errors++;
    $display("%s at %0t ns", what, $time);
  endtask

  task automatic abort_run(input string what);
    report_failure({"timeout: ", what});
    aborted = 1'b1;
  endtask

  function automatic int pending_count();
    int n;
    n = st_addr_q.size();
    for (int r = 0; r < core_pkg::REG_COUNT; r++) begin
      n += exp_q[r].size();
    end
    return n;
  endfunction

  task automatic finish_test();
    tests_run++;
    if (test_errors != 0) begin
      tests_failed++;
    end
    $display("test %0d done: %0d errors, %0d stall cycles", test_num, test_errors, stall_cycles);
  endtask

  // called on a rising edge and returns on the edge where the word transferred.
  task automatic send_instr(input core_pkg::instr_t word);
    int waited;
    waited = 0;
    instr_valid_i <= 1'b1;
    instr_i       <= word;
    @(posedge clk_i);
    while (!instr_ready_o && !aborted) begin
      stall_cycles++;
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("instr_ready_o stayed low");
      end else begin
        @(posedge clk_i);
      end
    end
  endtask

  task automatic run_section();
    int waited;
    waited = 0;
    while (instr_q.size() != 0 && !aborted) begin
      send_instr(instr_q.pop_front());
    end
    instr_valid_i <= 1'b0;
    // decode may still hold a stalled word after the last transfer.
    while (pending_count() != 0 && !aborted) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("wb_valid_o or mem_req_o never delivered the expected results");
      end else begin
        @(posedge clk_i);
        if (!instr_ready_o) begin
          stall_cycles++;
        end
      end
    end
    if (need_stall != 0) begin
      check_eq(core_pkg::data_t'(stall_cycles != 0), 16'd1, "instr_ready_o low while stalled");
    end
    finish_test();
  endtask

  task automatic parse_line(input string line);
    core_pkg::instr_t    word;
    core_pkg::reg_addr_t rd;
    core_pkg::data_t     val;
    core_pkg::data_t     addr;
    int                  n;
    n = 0;
    case (line[0])
      "T": begin
        if (sect_open) begin
          run_section();
        end
        n = $sscanf(line, "T %d %d", test_num, need_stall);
        test_errors  = 0;
        stall_cycles = 0;
        sect_open    = 1'b1;
      end
      "I": begin
        n = $sscanf(line, "I %h", word);
        instr_q.push_back(word);
      end
      "W": begin
        n = $sscanf(line, "W %h %h", rd, val);
        exp_q[rd].push_back(val);
      end
      "S": begin
        n = $sscanf(line, "S %h %h", addr, val);
        st_addr_q.push_back(addr);
        st_data_q.push_back(val);
      end
      default: begin
        n = 0;
      end
    endcase
    if (n < 1) begin
      report_failure({"unreadable trace line: ", line});
    end
  endtask

  always @(posedge clk_i) begin
    if (rst_n_i && wb_valid_o) begin
      if (wb_rd_o == 4'd0) begin
        report_failure("writeback to r0 on the wb port");
      end else if (exp_q[wb_rd_o].size() == 0) begin
        report_failure($sformatf("unexpected writeback of %h to r%0d", wb_data_o, wb_rd_o));
      end else begin
        check_eq(wb_data_o, exp_q[wb_rd_o].pop_front(), $sformatf("writeback to r%0d", wb_rd_o));
      end
    end
  end

  // memory model acks 1 to 4 cycles after req and returns addr ^ a5a5.
  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      mem_ack_i <= 1'b0;
      ack_cnt   <= -1;
    end else if (mem_req_o && !mem_ack_i) begin
      if (ack_cnt < 0) begin
        ack_cnt <= $unsigned($random(seed)) % 4;
        if (mem_we_o && st_addr_q.size() == 0) begin
          report_failure($sformatf("unexpected store to %h", mem_addr_o));
        end else if (mem_we_o) begin
          check_eq(mem_addr_o, st_addr_q.pop_front(), "store address");
          check_eq(mem_wdata_o, st_data_q.pop_front(), "store data");
        end
      end else if (ack_cnt == 0) begin
        mem_ack_i   <= 1'b1;
        mem_rdata_i <= mem_addr_o ^ 16'hA5A5;
        ack_cnt     <= -1;
      end else begin
        ack_cnt <= ack_cnt - 1;
      end
    end else if (!mem_req_o && mem_ack_i) begin
      mem_ack_i <= 1'b0;
    end
  end

  initial begin
    int    fd;
    string line;
    int    waited;
    fd = $fopen("tests/core_trace.txt", "r");
    // outputs are only defined after the first reset edge.
    for (int i = 0; i < 4; i++) begin
      @(posedge clk_i);
      if (i > 0) begin
        check_eq(core_pkg::data_t'(instr_ready_o), '0, "instr_ready_o in reset");
        check_eq(core_pkg::data_t'(mem_req_o), '0, "mem_req_o in reset");
        check_eq(core_pkg::data_t'(wb_valid_o), '0, "wb_valid_o in reset");
      end
    end
    rst_n_i <= 1'b1;
    repeat (8) @(posedge clk_i);
    finish_test();
    if (fd == 0) begin
      report_failure("cannot open tests/core_trace.txt");
    end else begin
      while (!aborted && $fgets(line, fd) != 0) begin
        if (line.len() > 1 && line[0] != "#") begin
          parse_line(line);
        end
      end
      $fclose(fd);
      if (sect_open && !aborted) begin
        run_section();
      end
    end
    waited = 0;
    while ((mem_req_o || mem_ack_i) && !aborted) begin
      waited++;
      if (waited > WAIT_LIMIT) begin
        abort_run("mem_req_o or mem_ack_i stayed high");
      end else begin
        @(posedge clk_i);
      end
    end
    // any stray writeback shows up in this quiet window.
    repeat (12) @(posedge clk_i);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : core_tb

// ==== tests/core_assert.sv ====
`timescale 1ns/1ns

module core_assert (
  input logic                clk_i,
  input logic                rst_n_i,
  input logic                mem_req_i,
  input logic                mem_ack_i,
  input logic                wb_valid_i,
  input core_pkg::reg_addr_t wb_rd_i,
  input logic                alu_valid_i,
  input logic                mul_valid_i
);

  ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_ack_i) |-> mem_req_i)
    else $error("mem_ack_i rose without mem_req_o");

  // four-phase, ack must be low before the next req.
  req_after_ack_low: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(mem_req_i) |-> !mem_ack_i)
    else $error("mem_req_o rose while mem_ack_i was high");

  no_r0_write: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |-> wb_rd_i != 4'd0)
    else $error("wb_valid_o with wb_rd_o of zero");

  one_writer: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(alu_valid_i && mul_valid_i))
    else $error("alu result and ex5 result in the same cycle");

endmodule : core_assert

// ==== logic/core_top.sv ====
`timescale 1ns/1ns

module core_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                instr_valid_i,
  input  core_pkg::instr_t    instr_i,
  input  logic                mem_ack_i,
  input  core_pkg::data_t     mem_rdata_i,
  output logic                instr_ready_o,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output core_pkg::data_t     mem_addr_o,
  output core_pkg::data_t     mem_wdata_o,
  output logic                wb_valid_o,
  output core_pkg::reg_addr_t wb_rd_o,
  output core_pkg::data_t     wb_data_o
);

  logic                                           stall_decode;
  logic                                           alu_bubble;
  logic                                           ex_bubble;
  core_pkg::reg_addr_t                            rd_addr_a;
  core_pkg::reg_addr_t                            rd_addr_b;
  core_pkg::data_t                                rd_data_a;
  core_pkg::data_t                                rd_data_b;
  logic [core_pkg::MUL_STAGES-1:0]                ex_valid;
  core_pkg::reg_addr_t [core_pkg::MUL_STAGES-2:0] ex_wr_reg;
  logic                                           wb_is_next_cycle;
  logic                                           mem_busy;
  logic                                           alu_valid;
  core_pkg::reg_addr_t                            alu_rd;
  core_pkg::data_t                                alu_result;
  logic                                           mul_valid;
  core_pkg::reg_addr_t                            mul_rd;
  core_pkg::data_t                                mul_result;
  logic                                           ld_valid;
  core_pkg::reg_addr_t                            ld_rd;
  core_pkg::data_t                                ld_data;

  issue_if iss_bus ();

  instr_decode instr_decode_inst (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_i        (instr_i),
    .stall_decode_i (stall_decode),
    .alu_bubble_i   (alu_bubble),
    .ex_bubble_i    (ex_bubble),
    .rd_data_a_i    (rd_data_a),
    .rd_data_b_i    (rd_data_b),
    .instr_ready_o  (instr_ready_o),
    .rd_addr_a_o    (rd_addr_a),
    .rd_addr_b_o    (rd_addr_b),
    .iss            (iss_bus.src)
  );

  hazard_unit hazard_unit_inst (
    .dec                (iss_bus.mon),
    .mem_busy_i         (mem_busy),
    .wb_is_next_cycle_i (wb_is_next_cycle),
    .ex_valid_i         (ex_valid),
    .ex_wr_reg_i        (ex_wr_reg),
    .stall_decode_o     (stall_decode),
    .alu_bubble_o       (alu_bubble),
    .ex_bubble_o        (ex_bubble)
  );

  exec_pipe exec_pipe_inst (
    .clk_i              (clk_i),
    .rst_n_i            (rst_n_i),
    .iss                (iss_bus.dst),
    .alu_valid_o        (alu_valid),
    .alu_rd_o           (alu_rd),
    .alu_result_o       (alu_result),
    .ex_valid_o         (ex_valid),
    .ex_wr_reg_o        (ex_wr_reg),
    .wb_is_next_cycle_o (wb_is_next_cycle),
    .mul_valid_o        (mul_valid),
    .mul_rd_o           (mul_rd),
    .mul_result_o       (mul_result)
  );

  mem_port mem_port_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .iss         (iss_bus.dst),
    .mem_ack_i   (mem_ack_i),
    .mem_rdata_i (mem_rdata_i),
    .mem_req_o   (mem_req_o),
    .mem_we_o    (mem_we_o),
    .mem_addr_o  (mem_addr_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_busy_o  (mem_busy),
    .ld_valid_o  (ld_valid),
    .ld_rd_o     (ld_rd),
    .ld_data_o   (ld_data)
  );

  result_wb result_wb_inst (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .alu_valid_i (alu_valid),
    .alu_rd_i    (alu_rd),
    .alu_data_i  (alu_result),
    .mul_valid_i (mul_valid),
    .mul_rd_i    (mul_rd),
    .mul_data_i  (mul_result),
    .ld_valid_i  (ld_valid),
    .ld_rd_i     (ld_rd),
    .ld_data_i   (ld_data),
    .rd_addr_a_i (rd_addr_a),
    .rd_addr_b_i (rd_addr_b),
    .rd_data_a_o (rd_data_a),
    .rd_data_b_o (rd_data_b),
    .wb_valid_o  (wb_valid_o),
    .wb_rd_o     (wb_rd_o),
    .wb_data_o   (wb_data_o)
  );

endmodule : core_top

// ==== logic/result_wb.sv ====
`timescale 1ns/1ns

module result_wb (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                alu_valid_i,
  input  core_pkg::reg_addr_t alu_rd_i,
  input  core_pkg::data_t     alu_data_i,
  input  logic                mul_valid_i,
  input  core_pkg::reg_addr_t mul_rd_i,
  input  core_pkg::data_t     mul_data_i,
  input  logic                ld_valid_i,
  input  core_pkg::reg_addr_t ld_rd_i,
  input  core_pkg::data_t     ld_data_i,
  input  core_pkg::reg_addr_t rd_addr_a_i,
  input  core_pkg::reg_addr_t rd_addr_b_i,
  output core_pkg::data_t     rd_data_a_o,
  output core_pkg::data_t     rd_data_b_o,
  output logic                wb_valid_o,
  output core_pkg::reg_addr_t wb_rd_o,
  output core_pkg::data_t     wb_data_o
);

  core_pkg::data_t regs [core_pkg::REG_COUNT];
  logic            sel_valid;

  // hazard rules leave at most one source valid.
  always_comb begin
    sel_valid = 1'b1;
    wb_rd_o   = alu_rd_i;
    wb_data_o = alu_data_i;
    if (mul_valid_i) begin
      wb_rd_o   = mul_rd_i;
      wb_data_o = mul_data_i;
    end else if (ld_valid_i) begin
      wb_rd_o   = ld_rd_i;
      wb_data_o = ld_data_i;
    end else if (!alu_valid_i) begin
      sel_valid = 1'b0;
    end
  end

  assign wb_valid_o = sel_valid && wb_rd_o != core_pkg::ZERO_REG;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < core_pkg::REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid_o) begin
      regs[wb_rd_o] <= wb_data_o;
    end
  end

  // write-through so decode sees this cycle's result.
  function automatic core_pkg::data_t read_port(core_pkg::reg_addr_t addr);
    if (addr == core_pkg::ZERO_REG) begin
      return '0;
    end
    if (wb_valid_o && wb_rd_o == addr) begin
      return wb_data_o;
    end
    return regs[addr];
  endfunction

  assign rd_data_a_o = read_port(rd_addr_a_i);
  assign rd_data_b_o = read_port(rd_addr_b_i);

endmodule : result_wb

// ==== logic/mem_port.sv ====
`timescale 1ns/1ns

module mem_port (
  input  logic                clk_i,
  input  logic                rst_n_i,
  issue_if.dst                iss,
  input  logic                mem_ack_i,
  input  core_pkg::data_t     mem_rdata_i,
  output logic                mem_req_o,
  output logic                mem_we_o,
  output core_pkg::data_t     mem_addr_o,
  output core_pkg::data_t     mem_wdata_o,
  output logic                mem_busy_o,
  output logic                ld_valid_o,
  output core_pkg::reg_addr_t ld_rd_o,
  output core_pkg::data_t     ld_data_o
);

  core_pkg::mem_state_e state;
  logic                 mem_issue;

  assign mem_issue = iss.valid && (iss.op == core_pkg::OP_LD || iss.op == core_pkg::OP_ST);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state      <= core_pkg::MEM_IDLE;
      mem_we_o   <= 1'b0;
      ld_valid_o <= 1'b0;
    end else begin
      ld_valid_o <= 1'b0;
      case (state)
        core_pkg::MEM_IDLE: begin
          if (mem_issue) begin
            state    <= core_pkg::MEM_REQ;
            mem_we_o <= iss.op == core_pkg::OP_ST;
          end
        end
        core_pkg::MEM_REQ: begin
          if (mem_ack_i) begin
            state      <= core_pkg::MEM_WAIT_LOW;
            ld_valid_o <= !mem_we_o;
          end
        end
        core_pkg::MEM_WAIT_LOW: begin
          // next req only after ack has dropped.
          if (!mem_ack_i) begin
            state <= core_pkg::MEM_IDLE;
          end
        end
        default: state <= core_pkg::MEM_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == core_pkg::MEM_IDLE && mem_issue) begin
      mem_addr_o  <= iss.a + iss.imm;
      mem_wdata_o <= iss.b;
      ld_rd_o     <= iss.rd;
    end
    if (state == core_pkg::MEM_REQ && mem_ack_i) begin
      ld_data_o <= mem_rdata_i;
    end
  end

  assign mem_req_o  = state == core_pkg::MEM_REQ;
  assign mem_busy_o = state != core_pkg::MEM_IDLE;

endmodule : mem_port

// ==== logic/exec_pipe.sv ====
`timescale 1ns/1ns

module exec_pipe (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  issue_if.dst                                           iss,
  output logic                                           alu_valid_o,
  output core_pkg::reg_addr_t                            alu_rd_o,
  output core_pkg::data_t                                alu_result_o,
  output logic [core_pkg::MUL_STAGES-1:0]                ex_valid_o,
  output core_pkg::reg_addr_t [core_pkg::MUL_STAGES-2:0] ex_wr_reg_o,
  output logic                                           wb_is_next_cycle_o,
  output logic                                           mul_valid_o,
  output core_pkg::reg_addr_t                            mul_rd_o,
  output core_pkg::data_t                                mul_result_o
);

  logic                                           is_alu;
  logic                                           mul_issue;
  core_pkg::data_t                                alu_calc;
  core_pkg::reg_addr_t [core_pkg::MUL_STAGES-1:0] ex_rd;
  core_pkg::data_t                                ex1_a;
  core_pkg::data_t                                ex1_b;
  core_pkg::data_t                                ex2_a;
  core_pkg::data_t                                ex2_b;
  core_pkg::data_t                                ex3_p;
  core_pkg::data_t                                ex4_p;
  core_pkg::data_t                                ex5_p;

  always_comb begin
    is_alu   = 1'b1;
    alu_calc = iss.a + iss.b;
    case (iss.op)
      core_pkg::OP_ADD:  alu_calc = iss.a + iss.b;
      core_pkg::OP_SUB:  alu_calc = iss.a - iss.b;
      core_pkg::OP_AND:  alu_calc = iss.a & iss.b;
      core_pkg::OP_XOR:  alu_calc = iss.a ^ iss.b;
      core_pkg::OP_ADDI: alu_calc = iss.a + iss.imm;
      default:           is_alu = 1'b0;
    endcase
  end

  assign mul_issue = iss.valid && iss.op == core_pkg::OP_MUL;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      alu_valid_o <= 1'b0;
      ex_valid_o  <= '0;
    end else begin
      alu_valid_o <= iss.valid && is_alu;
      ex_valid_o  <= {ex_valid_o[core_pkg::MUL_STAGES-2:0], mul_issue};
    end
  end

  always_ff @(posedge clk_i) begin
    alu_rd_o     <= iss.rd;
    alu_result_o <= alu_calc;
    ex_rd        <= {ex_rd[core_pkg::MUL_STAGES-2:0], iss.rd};
    ex1_a        <= iss.a;
    ex1_b        <= iss.b;
    ex2_a        <= ex1_a;
    ex2_b        <= ex1_b;
    // low half of the product.
    ex3_p        <= ex2_a * ex2_b;
    ex4_p        <= ex3_p;
    ex5_p        <= ex4_p;
  end

  assign ex_wr_reg_o  = ex_rd[core_pkg::MUL_STAGES-2:0];
  assign mul_valid_o  = ex_valid_o[core_pkg::MUL_STAGES-1];
  assign mul_rd_o     = ex_rd[core_pkg::MUL_STAGES-1];
  assign mul_result_o = ex5_p;

  // ex4 now, so ex5 and the write port next cycle.
  assign wb_is_next_cycle_o = ex_valid_o[core_pkg::MUL_STAGES-2];

endmodule : exec_pipe

// ==== logic/hazard_unit.sv ====
`timescale 1ns/1ns

module hazard_unit (
  issue_if.mon                                      dec,
  input  logic                                      mem_busy_i,
  input  logic                                      wb_is_next_cycle_i,
  input  logic [core_pkg::MUL_STAGES-1:0]           ex_valid_i,
  input  core_pkg::reg_addr_t [core_pkg::MUL_STAGES-2:0] ex_wr_reg_i,
  output logic                                      stall_decode_o,
  output logic                                      alu_bubble_o,
  output logic                                      ex_bubble_o
);

  logic is_mem;
  logic is_wb_fast;
  logic raw_rs1;
  logic raw_rs2;
  logic waw;
  logic reg_hazard;

  always_comb begin
    is_mem     = 1'b0;
    is_wb_fast = 1'b0;
    case (dec.op)
      core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND,
      core_pkg::OP_XOR, core_pkg::OP_ADDI: begin
        is_wb_fast = 1'b1;
      end
      core_pkg::OP_LD: begin
        is_mem     = 1'b1;
        is_wb_fast = 1'b1;
      end
      core_pkg::OP_ST: begin
        is_mem = 1'b1;
      end
      default: begin
      end
    endcase
  end

  // ex5 result reaches decode through the regfile bypass.
  always_comb begin
    raw_rs1 = 1'b0;
    raw_rs2 = 1'b0;
    waw     = 1'b0;
    for (int i = 0; i < core_pkg::MUL_STAGES - 1; i++) begin
      if (ex_valid_i[i]) begin
        if (dec.rs1_needed && dec.rs1 != core_pkg::ZERO_REG && ex_wr_reg_i[i] == dec.rs1) begin
          raw_rs1 = 1'b1;
        end
        if (dec.rs2_needed && dec.rs2 != core_pkg::ZERO_REG && ex_wr_reg_i[i] == dec.rs2) begin
          raw_rs2 = 1'b1;
        end
        if (dec.rd_written && dec.rd != core_pkg::ZERO_REG && ex_wr_reg_i[i] == dec.rd) begin
          waw = 1'b1;
        end
      end
    end
  end

  assign reg_hazard = raw_rs1 || raw_rs2 || waw;

  always_comb begin
    stall_decode_o = 1'b0;
    alu_bubble_o   = 1'b0;
    ex_bubble_o    = 1'b0;
    if (mem_busy_i || reg_hazard) begin
      stall_decode_o = 1'b1;
      alu_bubble_o   = 1'b1;
      ex_bubble_o    = 1'b1;
    end else if (is_wb_fast && (wb_is_next_cycle_i || ex_valid_i[core_pkg::MUL_STAGES-1])) begin
      // multiply owns the write port now or next cycle.
      stall_decode_o = 1'b1;
      alu_bubble_o   = 1'b1;
    end else if (is_mem && (ex_valid_i[0] || ex_valid_i[1])) begin
      stall_decode_o = 1'b1;
    end
  end

endmodule : hazard_unit

// ==== logic/instr_decode.sv ====
`timescale 1ns/1ns

module instr_decode (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  logic                instr_valid_i,
  input  core_pkg::instr_t    instr_i,
  input  logic                stall_decode_i,
  input  logic                alu_bubble_i,
  input  logic                ex_bubble_i,
  input  core_pkg::data_t     rd_data_a_i,
  input  core_pkg::data_t     rd_data_b_i,
  output logic                instr_ready_o,
  output core_pkg::reg_addr_t rd_addr_a_o,
  output core_pkg::reg_addr_t rd_addr_b_o,
  issue_if.src                iss
);

  core_pkg::instr_t  ir;
  logic              ir_valid;
  logic              ready_en;
  logic              take;
  core_pkg::opcode_e op;
  logic              is_alu;
  logic              is_mul;
  logic              is_ld;
  logic              use_rs1;
  logic              use_rs2;

  assign take          = instr_valid_i && instr_ready_o;
  assign instr_ready_o = ready_en && !stall_decode_i;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ready_en <= 1'b0;
      ir_valid <= 1'b0;
    end else begin
      ready_en <= 1'b1;
      if (take) begin
        ir_valid <= 1'b1;
      end else if (iss.valid) begin
        ir_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      ir <= instr_i;
    end
  end

  // empty decode register looks like a nop.
  assign op = ir_valid ? core_pkg::opcode_e'(ir[core_pkg::OPC_LSB +: 4]) : core_pkg::OP_NOP;

  always_comb begin
    is_alu  = 1'b0;
    is_mul  = 1'b0;
    is_ld   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    case (op)
      core_pkg::OP_ADD, core_pkg::OP_SUB, core_pkg::OP_AND, core_pkg::OP_XOR: begin
        is_alu  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      core_pkg::OP_ADDI: begin
        is_alu  = 1'b1;
        use_rs1 = 1'b1;
      end
      core_pkg::OP_MUL: begin
        is_mul  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      core_pkg::OP_LD: begin
        is_ld   = 1'b1;
        use_rs1 = 1'b1;
      end
      core_pkg::OP_ST: begin
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      default: begin
      end
    endcase
  end

  assign rd_addr_a_o = ir[core_pkg::RS1_LSB +: 4];
  assign rd_addr_b_o = ir[core_pkg::RS2_LSB +: 4];

  assign iss.op         = op;
  assign iss.rd         = ir[core_pkg::RD_LSB +: 4];
  assign iss.rs1        = rd_addr_a_o;
  assign iss.rs2        = rd_addr_b_o;
  assign iss.rs1_needed = use_rs1;
  assign iss.rs2_needed = use_rs2;
  assign iss.rd_written = is_alu || is_mul || is_ld;
  assign iss.a          = rd_data_a_i;
  assign iss.b          = rd_data_b_i;
  assign iss.imm        = ir[15:0];

  // each bubble holds back only the unit it names.
  assign iss.valid = ir_valid && !stall_decode_i
                     && !((is_alu || is_ld) && alu_bubble_i)
                     && !(is_mul && ex_bubble_i);

endmodule : instr_decode

// ==== logic/issue_if.sv ====
`timescale 1ns/1ns

interface issue_if;

  logic                valid;
  core_pkg::opcode_e   op;
  core_pkg::reg_addr_t rd;
  core_pkg::reg_addr_t rs1;
  core_pkg::reg_addr_t rs2;
  logic                rs1_needed;
  logic                rs2_needed;
  logic                rd_written;
  core_pkg::data_t     a;
  core_pkg::data_t     b;
  core_pkg::data_t     imm;

  modport src (output valid, op, rd, rs1, rs2,
               output rs1_needed, rs2_needed, rd_written,
               output a, b, imm);

  modport dst (input valid, op, rd, a, b, imm);

  // hazard view, no valid here since valid depends on the stall.
  modport mon (input op, rd, rs1, rs2, rs1_needed, rs2_needed, rd_written);

endinterface : issue_if

// ==== logic/core_pkg.sv ====
package core_pkg;

  typedef logic [3:0]  reg_addr_t;
  typedef logic [15:0] data_t;
  typedef logic [31:0] instr_t;

  // opcode field, bits 31:28 of the instruction.
  typedef enum logic [3:0] {
    OP_NOP  = 4'd0,
    OP_ADD  = 4'd1,
    OP_SUB  = 4'd2,
    OP_AND  = 4'd3,
    OP_XOR  = 4'd4,
    OP_ADDI = 4'd5,
    OP_MUL  = 4'd6,
    OP_LD   = 4'd7,
    OP_ST   = 4'd8
  } opcode_e;

  // four-phase req/ack sequencer.
  typedef enum logic [1:0] {
    MEM_IDLE     = 2'd0,
    MEM_REQ      = 2'd1,
    MEM_WAIT_LOW = 2'd2
  } mem_state_e;

  localparam int MUL_STAGES = 5;
  localparam int REG_COUNT  = 16;

  // low bit of each instruction field.
  localparam int OPC_LSB = 28;
  localparam int RD_LSB  = 24;
  localparam int RS1_LSB = 20;
  localparam int RS2_LSB = 16;

  // r0 always reads as zero.
  localparam reg_addr_t ZERO_REG = 4'd0;

endpackage : core_pkg
